/* hw/stamofu_params.svh */
// size macros for the store/AMO/fence dispatch path, included by the package and every RTL file

`ifndef STAMOFU_PARAMS_SVH
`define STAMOFU_PARAMS_SVH

// dispatch width
`define STAMOFU_DISPATCH_WAYS 2

// queue depths and their index widths
`define STAMOFU_DQ_ENTRIES 4
`define LOG_STAMOFU_DQ_ENTRIES 2
`define STAMOFU_CQ_ENTRIES 8
`define LOG_STAMOFU_CQ_ENTRIES 3

// core-wide tag widths
`define LOG_PR_COUNT 6
`define LOG_ROB_ENTRIES 5

`endif

/* hw/stamofu_pkg.sv */
// shared types for the store/AMO/fence dispatch path, imported by every stamofu module

`include "stamofu_params.svh"

package stamofu_pkg;

	// --------------------------------------------------
	// op encodings

	typedef enum logic [1:0] {
		CLASS_STORE = 2'd0,
		CLASS_AMO   = 2'd1,
		CLASS_FENCE = 2'd2
	} op_class_t;

	// funct3-like store sizes, amo ops above
	typedef enum logic [3:0] {
		SB       = 4'h0,
		SH       = 4'h1,
		SW       = 4'h2,
		AMO_SWAP = 4'h4,
		AMO_ADD  = 4'h5,
		FENCE    = 4'hF
	} mem_op_t;

	// --------------------------------------------------
	// dispatch and queue records

	typedef struct packed {
		logic                          attempt;
		op_class_t                     op_class;
		mem_op_t                       op;
		logic [11:0]                   imm12;
		logic                          mem_aq;
		logic                          io_aq;
		logic [`LOG_PR_COUNT-1:0]      A_PR;
		logic                          A_ready;
		logic                          A_is_zero;
		logic [`LOG_PR_COUNT-1:0]      B_PR;
		logic                          B_ready;
		logic                          B_is_zero;
		logic [`LOG_PR_COUNT-1:0]      dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]   ROB_index;
	} dispatch_op_t;

	typedef struct packed {
		logic                          valid;
		logic                          killed;
		op_class_t                     op_class;
		mem_op_t                       op;
		logic [11:0]                   imm12;
		logic                          mem_aq;
		logic                          io_aq;
		logic [`LOG_PR_COUNT-1:0]      A_PR;
		logic                          A_ready;
		logic                          A_is_zero;
		logic [`LOG_PR_COUNT-1:0]      B_PR;
		logic                          B_ready;
		logic                          B_is_zero;
		logic [`LOG_PR_COUNT-1:0]      dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]   ROB_index;
	} dq_entry_t;

	typedef struct packed {
		op_class_t                     op_class;
		mem_op_t                       op;
		logic                          killed;
		logic                          mem_aq;
		logic                          io_aq;
		logic [`LOG_PR_COUNT-1:0]      dest_PR;
		logic [`LOG_ROB_ENTRIES-1:0]   ROB_index;
	} cq_enq_t;

	typedef struct packed {
		op_class_t                       op_class;
		mem_op_t                         op;
		logic [11:0]                     imm12;
		logic [`LOG_PR_COUNT-1:0]        A_PR;
		logic                            A_ready;
		logic                            A_is_zero;
		logic [`LOG_PR_COUNT-1:0]        B_PR;
		logic                            B_ready;
		logic                            B_is_zero;
		logic [`LOG_ROB_ENTRIES-1:0]     ROB_index;
		logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] cq_index;
	} iq_enq_t;

	typedef struct packed {
		logic                          mem_aq;
		logic                          io_aq;
		logic [`LOG_ROB_ENTRIES-1:0]   ROB_index;
	} aq_enq_t;

	// --------------------------------------------------
	// core broadcasts

	typedef struct packed {
		logic                          valid;
		logic [`LOG_PR_COUNT-1:0]      PR;
	} wb_bus_t;

	typedef struct packed {
		logic                          valid;
		logic [`LOG_ROB_ENTRIES-1:0]   abs_head_index;
		logic [`LOG_ROB_ENTRIES-1:0]   rel_kill_younger_index;
	} rob_kill_t;

endpackage

/* hw/stamofu_dispatch.sv */
// producer stage: grants dispatch ways in order against dq room, builds dq entries, registers acks

`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_dispatch import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input dispatch_op_t [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_by_way,
	output logic [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// dq write port
	input logic [`LOG_STAMOFU_DQ_ENTRIES:0] dq_free_count,
	output logic [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_valid_by_way,
	output dq_entry_t [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_entry_by_way
);

	logic [`LOG_STAMOFU_DQ_ENTRIES:0] room;
	logic blocked;

	// fresh entry: valid, not killed, operand state as dispatched
	function automatic dq_entry_t build_entry(input dispatch_op_t d);
		dq_entry_t e;
		e.valid = 1'b1;
		e.killed = 1'b0;
		e.op_class = d.op_class;
		e.op = d.op;
		e.imm12 = d.imm12;
		e.mem_aq = d.mem_aq;
		e.io_aq = d.io_aq;
		e.A_PR = d.A_PR;
		e.A_ready = d.A_ready;
		e.A_is_zero = d.A_is_zero;
		e.B_PR = d.B_PR;
		e.B_ready = d.B_ready;
		e.B_is_zero = d.B_is_zero;
		e.dest_PR = d.dest_PR;
		e.ROB_index = d.ROB_index;
		return e;
	endfunction

	// --------------------------------------------------
	// in-order grant, first refused way blocks all later ones
	always_comb begin
		room = dq_free_count;
		blocked = 1'b0;
		for (int w = 0; w < `STAMOFU_DISPATCH_WAYS; w++) begin
			dq_write_valid_by_way[w] = 1'b0;
			dq_write_entry_by_way[w] = build_entry(dispatch_by_way[w]);
			if (dispatch_by_way[w].attempt && !blocked) begin
				if (room != '0) begin
					dq_write_valid_by_way[w] = 1'b1;
					room = room - 1'b1;
				end else begin
					blocked = 1'b1;
				end
			end
		end
	end

	// ack on the same edge the dq takes the write
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dispatch_ack_by_way <= '0;
		end else begin
			dispatch_ack_by_way <= dq_write_valid_by_way;
		end
	end

endmodule

/* hw/stamofu_dq.sv */
// dispatch queue: buffers accepted ops, tracks operand wakeup and kills, drains the head in order

`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_dq import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// write from the producer
	input logic [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_valid_by_way,
	input dq_entry_t [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_entry_by_way,
	output logic [`LOG_STAMOFU_DQ_ENTRIES:0] dq_free_count,

	// core broadcasts
	input wb_bus_t wb_bus,
	input rob_kill_t rob_kill,

	// central queue
	output logic cq_enq_valid,
	output cq_enq_t cq_enq,
	input logic cq_enq_ready,
	input logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] cq_enq_index,

	// issue and acquire queues
	output logic iq_enq_valid,
	output iq_enq_t iq_enq,
	input logic iq_enq_ready,
	output logic aq_enq_valid,
	output aq_enq_t aq_enq,
	input logic aq_enq_ready
);

	localparam logic [`LOG_STAMOFU_DQ_ENTRIES:0] DQ_DEPTH = `STAMOFU_DQ_ENTRIES;

	dq_entry_t [`STAMOFU_DQ_ENTRIES-1:0] entry_q;
	dq_entry_t [`STAMOFU_DQ_ENTRIES-1:0] entry_upd;
	dq_entry_t [`STAMOFU_DQ_ENTRIES-1:0] entry_next;
	logic [`LOG_STAMOFU_DQ_ENTRIES-1:0] head;
	logic [`LOG_STAMOFU_DQ_ENTRIES-1:0] tail;
	logic [`LOG_STAMOFU_DQ_ENTRIES:0] count;
	logic [`LOG_STAMOFU_DQ_ENTRIES:0] write_count;
	logic [`STAMOFU_DISPATCH_WAYS-1:0][`LOG_STAMOFU_DQ_ENTRIES-1:0] write_index;
	dq_entry_t head_entry;
	logic needs_iq;
	logic needs_aq;
	logic deq;

	// apply this cycle's writeback and kill to one entry
	function automatic dq_entry_t wake_and_kill(input dq_entry_t e);
		dq_entry_t r;
		logic [`LOG_ROB_ENTRIES-1:0] rel_index;
		r = e;
		rel_index = e.ROB_index - rob_kill.abs_head_index;
		if (e.A_is_zero || (wb_bus.valid && wb_bus.PR == e.A_PR))
			r.A_ready = 1'b1;
		if (e.B_is_zero || (wb_bus.valid && wb_bus.PR == e.B_PR))
			r.B_ready = 1'b1;
		if (rob_kill.valid && rel_index >= rob_kill.rel_kill_younger_index)
			r.killed = 1'b1;
		return r;
	endfunction

	assign dq_free_count = DQ_DEPTH - count;

	// --------------------------------------------------
	// write slots, packed from the tail in way order
	always_comb begin
		write_count = '0;
		for (int w = 0; w < `STAMOFU_DISPATCH_WAYS; w++) begin
			write_index[w] = tail + write_count[`LOG_STAMOFU_DQ_ENTRIES-1:0];
			if (dq_write_valid_by_way[w])
				write_count = write_count + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < `STAMOFU_DQ_ENTRIES; i++)
			entry_upd[i] = wake_and_kill(entry_q[i]);
	end

	// --------------------------------------------------
	// head routing
	assign head_entry = entry_upd[head];
	assign needs_iq = !head_entry.killed
		&& (head_entry.op_class == CLASS_STORE || head_entry.op_class == CLASS_AMO);
	assign needs_aq = !head_entry.killed && (head_entry.mem_aq || head_entry.io_aq);

	// skip the cycle after a dequeue so cq ready and tail have settled
	assign deq = head_entry.valid && !cq_enq_valid && cq_enq_ready
		&& (iq_enq_ready || !needs_iq) && (aq_enq_ready || !needs_aq);

	always_comb begin
		entry_next = entry_upd;
		if (deq)
			entry_next[head].valid = 1'b0;
		for (int w = 0; w < `STAMOFU_DISPATCH_WAYS; w++) begin
			if (dq_write_valid_by_way[w])
				entry_next[write_index[w]] = wake_and_kill(dq_write_entry_by_way[w]);
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			entry_q <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			cq_enq_valid <= 1'b0;
			iq_enq_valid <= 1'b0;
			aq_enq_valid <= 1'b0;
		end else begin
			entry_q <= entry_next;
			if (deq)
				head <= head + 1'b1;
			tail <= tail + write_count[`LOG_STAMOFU_DQ_ENTRIES-1:0];
			count <= count + write_count - {{`LOG_STAMOFU_DQ_ENTRIES{1'b0}}, deq};
			cq_enq_valid <= deq;
			iq_enq_valid <= deq && needs_iq;
			aq_enq_valid <= deq && needs_aq;
		end
	end

	// enqueue payloads, meaningful only with their valid
	always_ff @(posedge CLK) begin
		if (deq) begin
			cq_enq.op_class <= head_entry.op_class;
			cq_enq.op <= head_entry.op;
			cq_enq.killed <= head_entry.killed;
			cq_enq.mem_aq <= head_entry.mem_aq;
			cq_enq.io_aq <= head_entry.io_aq;
			cq_enq.dest_PR <= head_entry.dest_PR;
			cq_enq.ROB_index <= head_entry.ROB_index;
			iq_enq.op_class <= head_entry.op_class;
			iq_enq.op <= head_entry.op;
			iq_enq.imm12 <= head_entry.imm12;
			iq_enq.A_PR <= head_entry.A_PR;
			iq_enq.A_ready <= head_entry.A_ready;
			iq_enq.A_is_zero <= head_entry.A_is_zero;
			iq_enq.B_PR <= head_entry.B_PR;
			iq_enq.B_ready <= head_entry.B_ready;
			iq_enq.B_is_zero <= head_entry.B_is_zero;
			iq_enq.ROB_index <= head_entry.ROB_index;
			iq_enq.cq_index <= cq_enq_index;
			aq_enq.mem_aq <= head_entry.mem_aq;
			aq_enq.io_aq <= head_entry.io_aq;
			aq_enq.ROB_index <= head_entry.ROB_index;
		end
	end

endmodule

/* hw/stamofu_cq.sv */
// central queue: allocates cq indices at its tail, holds the ops and frees them in order on commit

`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_cq import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// enqueue from the dq
	input logic cq_enq_valid,
	input cq_enq_t cq_enq,
	output logic cq_enq_ready,
	output logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] cq_enq_index,

	// commit and occupancy
	input logic commit_valid,
	output logic [`LOG_STAMOFU_CQ_ENTRIES:0] cq_count
);

	cq_enq_t [`STAMOFU_CQ_ENTRIES-1:0] op_q;
	logic [`STAMOFU_CQ_ENTRIES-1:0] valid_q;
	logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] head;
	logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] tail;
	logic [`LOG_STAMOFU_CQ_ENTRIES:0] count;
	logic enq;
	logic commit_ok;

	// not full while the tail slot is free
	assign cq_enq_ready = !valid_q[tail];
	assign cq_enq_index = tail;
	assign cq_count = count;

	assign enq = cq_enq_valid && cq_enq_ready;
	// commit on an empty queue is dropped
	assign commit_ok = commit_valid && valid_q[head];

	// --------------------------------------------------
	// pointers and occupancy
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (enq) begin
				valid_q[tail] <= 1'b1;
				tail <= tail + 1'b1;
			end
			if (commit_ok) begin
				valid_q[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({enq, commit_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// op storage
	always_ff @(posedge CLK) begin
		if (enq)
			op_q[tail] <= cq_enq;
	end

endmodule

/* hw/stamofu_top.sv */
// top level of the store/AMO/fence dispatch path: producer, dispatch queue and central queue

`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_top import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// dispatch
	input dispatch_op_t [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_by_way,
	output logic [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// core broadcasts
	input wb_bus_t wb_bus,
	input rob_kill_t rob_kill,

	// issue queue
	output logic iq_enq_valid,
	output iq_enq_t iq_enq,
	input logic iq_enq_ready,

	// acquire queue
	output logic aq_enq_valid,
	output aq_enq_t aq_enq,
	input logic aq_enq_ready,

	// commit
	input logic commit_valid,
	output logic [`LOG_STAMOFU_CQ_ENTRIES:0] cq_count
);

	logic [`LOG_STAMOFU_DQ_ENTRIES:0] dq_free_count;
	logic [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_valid_by_way;
	dq_entry_t [`STAMOFU_DISPATCH_WAYS-1:0] dq_write_entry_by_way;
	logic cq_enq_valid;
	cq_enq_t cq_enq;
	logic cq_enq_ready;
	logic [`LOG_STAMOFU_CQ_ENTRIES-1:0] cq_enq_index;

	stamofu_dispatch dispatch (.*);

	stamofu_dq dq (.*);

	stamofu_cq cq (.*);

endmodule

/* tb/stamofu_asserts.sv */
// concurrent checks on the dispatch path, attached to stamofu_top by the bind at the end
`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_asserts import stamofu_pkg::*; (
	input logic CLK,
	input logic nRST,
	input dispatch_op_t [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_by_way,
	input logic [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_ack_by_way,
	input logic cq_enq_valid,
	input logic iq_enq_valid,
	input logic iq_enq_ready,
	input logic aq_enq_valid,
	input logic [`LOG_STAMOFU_CQ_ENTRIES:0] cq_count
);

	int fail_count = 0;

	// way 1 acked alone only when way 0 did not attempt
	ack_in_way_order: assert property (@(posedge CLK) disable iff (!nRST)
		(dispatch_ack_by_way[1] && !dispatch_ack_by_way[0])
		|-> !$past(dispatch_by_way[0].attempt))
		else begin
			$error("way 1 acked ahead of an attempting way 0");
			fail_count++;
		end

	ack_after_attempt: assert property (@(posedge CLK) disable iff (!nRST)
		(dispatch_ack_by_way
		& ~{$past(dispatch_by_way[1].attempt), $past(dispatch_by_way[0].attempt)}) == '0)
		else begin
			$error("ack without an attempt on the edge before");
			fail_count++;
		end

	iq_with_cq: assert property (@(posedge CLK) disable iff (!nRST)
		iq_enq_valid |-> cq_enq_valid)
		else begin
			$error("iq enqueue without a cq enqueue");
			fail_count++;
		end

	iq_after_ready: assert property (@(posedge CLK) disable iff (!nRST)
		iq_enq_valid |-> $past(iq_enq_ready))
		else begin
			$error("iq enqueue while iq ready was low");
			fail_count++;
		end

	cq_bounded: assert property (@(posedge CLK) disable iff (!nRST)
		cq_count <= `STAMOFU_CQ_ENTRIES)
		else begin
			$error("cq count above queue depth");
			fail_count++;
		end

	quiet_in_reset: assert property (@(posedge CLK)
		!nRST |-> !(cq_enq_valid || iq_enq_valid || aq_enq_valid || |dispatch_ack_by_way))
		else begin
			$error("valid or ack high during reset");
			fail_count++;
		end

endmodule

bind stamofu_top stamofu_asserts checks (
	.CLK(CLK),
	.nRST(nRST),
	.dispatch_by_way(dispatch_by_way),
	.dispatch_ack_by_way(dispatch_ack_by_way),
	.cq_enq_valid(cq_enq_valid),
	.iq_enq_valid(iq_enq_valid),
	.iq_enq_ready(iq_enq_ready),
	.aq_enq_valid(aq_enq_valid),
	.cq_count(cq_count)
);

/* tb/stamofu_tb.sv */
// testbench for the dispatch path: drives stamofu_top and models the expected iq and aq streams
`timescale 1ns/1ps

`include "stamofu_params.svh"

module stamofu_tb import stamofu_pkg::*; ();

	// longest test sequence is well under half of this
	localparam int TIMEOUT_CYCLES = 600;

	logic CLK;
	logic nRST;
	dispatch_op_t [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_by_way;
	logic [`STAMOFU_DISPATCH_WAYS-1:0] dispatch_ack_by_way;
	wb_bus_t wb_bus;
	rob_kill_t rob_kill;
	logic iq_enq_valid;
	iq_enq_t iq_enq;
	logic iq_enq_ready;
	logic aq_enq_valid;
	aq_enq_t aq_enq;
	logic aq_enq_ready;
	logic commit_valid;
	logic [`LOG_STAMOFU_CQ_ENTRIES:0] cq_count;

	// model state
	dispatch_op_t to_send[$];
	iq_enq_t exp_iq[$];
	aq_enq_t exp_aq[$];
	int seq = 0;
	int cq_model = 0;
	int errors = 0;
	int cycles = 0;
	string test_name = "reset";

	stamofu_top uut (.*);

	always #4 CLK = ~CLK;

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (expected === actual) else begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic print_counts();
		$display("summary: %0d testbench errors, %0d assertion failures", errors,
			uut.checks.fail_count);
	endtask

	function automatic dispatch_op_t make_op(input mem_op_t op, input logic [4:0] rob,
		input logic [5:0] a_pr, input logic a_rdy, input logic [5:0] b_pr, input logic b_rdy,
		input logic [1:0] aq);
		dispatch_op_t d;
		d.attempt = 1'b1;
		case (op)
			AMO_SWAP, AMO_ADD: d.op_class = CLASS_AMO;
			FENCE: d.op_class = CLASS_FENCE;
			default: d.op_class = CLASS_STORE;
		endcase
		d.op = op;
		d.imm12 = 12'($urandom);
		{d.mem_aq, d.io_aq} = aq;
		d.A_PR = a_pr;
		d.A_ready = a_rdy;
		d.A_is_zero = (a_pr == 6'd0);
		d.B_PR = b_pr;
		d.B_ready = b_rdy;
		d.B_is_zero = (b_pr == 6'd0);
		d.dest_PR = 6'($urandom);
		d.ROB_index = rob;
		return d;
	endfunction

	// accepted op gets the next cq slot in program order
	function automatic void accept_op(input dispatch_op_t d);
		iq_enq_t e;
		aq_enq_t a;
		e.op_class = d.op_class;
		e.op = d.op;
		e.imm12 = d.imm12;
		e.A_PR = d.A_PR;
		e.A_ready = d.A_ready || d.A_is_zero;
		e.A_is_zero = d.A_is_zero;
		e.B_PR = d.B_PR;
		e.B_ready = d.B_ready || d.B_is_zero;
		e.B_is_zero = d.B_is_zero;
		e.ROB_index = d.ROB_index;
		e.cq_index = seq[`LOG_STAMOFU_CQ_ENTRIES-1:0];
		a.mem_aq = d.mem_aq;
		a.io_aq = d.io_aq;
		a.ROB_index = d.ROB_index;
		seq++;
		cq_model++;
		if (d.op_class != CLASS_FENCE)
			exp_iq.push_back(e);
		if (d.mem_aq || d.io_aq)
			exp_aq.push_back(a);
	endfunction

	function automatic logic is_killed(input logic [4:0] rob, input logic [4:0] head,
		input logic [4:0] rel);
		logic [4:0] rel_index;
		rel_index = rob - head;
		return rel_index >= rel;
	endfunction

	// --------------------------------------------------
	// dispatch driver: retire acked ways, then present the next ops
	always @(posedge CLK) begin
		#1;
		for (int w = 0; w < `STAMOFU_DISPATCH_WAYS; w++) begin
			if (nRST && dispatch_ack_by_way[w])
				accept_op(to_send.pop_front());
		end
		for (int w = 0; w < `STAMOFU_DISPATCH_WAYS; w++) begin
			if (w < to_send.size())
				dispatch_by_way[w] = to_send[w];
			else
				dispatch_by_way[w] = '0;
		end
	end

	// iq and aq pulses against the model, in order
	always @(negedge CLK) begin
		if (iq_enq_valid) begin
			assert (exp_iq.size() != 0) else begin
				$display("error in %s: iq enqueue with no op expected", test_name);
				errors++;
			end
			if (exp_iq.size() != 0)
				check_value("iq_enq", exp_iq.pop_front(), iq_enq);
		end
		if (aq_enq_valid) begin
			assert (exp_aq.size() != 0) else begin
				$display("error in %s: aq enqueue with no op expected", test_name);
				errors++;
			end
			if (exp_aq.size() != 0)
				check_value("aq_enq", exp_aq.pop_front(), aq_enq);
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout in %s after %0d cycles", test_name, cycles);
			print_counts();
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus helpers
	task automatic writeback(input logic [5:0] pr);
		@(posedge CLK);
		#1;
		wb_bus.valid = 1'b1;
		wb_bus.PR = pr;
		foreach (exp_iq[i]) begin
			if (exp_iq[i].A_PR == pr)
				exp_iq[i].A_ready = 1'b1;
			if (exp_iq[i].B_PR == pr)
				exp_iq[i].B_ready = 1'b1;
		end
		@(posedge CLK);
		#1;
		wb_bus = '0;
	endtask

	task automatic kill(input logic [4:0] head, input logic [4:0] rel);
		@(posedge CLK);
		#1;
		rob_kill.valid = 1'b1;
		rob_kill.abs_head_index = head;
		rob_kill.rel_kill_younger_index = rel;
		for (int i = exp_iq.size() - 1; i >= 0; i--) begin
			if (is_killed(exp_iq[i].ROB_index, head, rel))
				exp_iq.delete(i);
		end
		for (int i = exp_aq.size() - 1; i >= 0; i--) begin
			if (is_killed(exp_aq[i].ROB_index, head, rel))
				exp_aq.delete(i);
		end
		@(posedge CLK);
		#1;
		rob_kill = '0;
	endtask

	task automatic commit(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
			commit_valid = 1'b1;
			if (cq_model > 0)
				cq_model--;
		end
		@(posedge CLK);
		#1;
		commit_valid = 1'b0;
	endtask

	task automatic set_iq_ready(input logic ready);
		@(posedge CLK);
		#1;
		iq_enq_ready = ready;
	endtask

	task automatic drain_and_check();
		int n;
		n = 0;
		while ((to_send.size() != 0 || exp_iq.size() != 0 || exp_aq.size() != 0
			|| cq_count != cq_model) && n < 40) begin
			@(negedge CLK);
			n++;
		end
		check_value("queues drained", 1,
			to_send.size() == 0 && exp_iq.size() == 0 && exp_aq.size() == 0);
		check_value("cq_count", cq_model, cq_count);
	endtask

	// --------------------------------------------------
	initial begin
		void'($urandom(9));
		CLK = 1'b0;
		nRST = 1'b1;
		dispatch_by_way = '0;
		wb_bus = '0;
		rob_kill = '0;
		iq_enq_ready = 1'b1;
		aq_enq_ready = 1'b1;
		commit_valid = 1'b0;
		#1;
		nRST = 1'b0;
		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;
		@(negedge CLK);
		check_value("valids and acks", 0, {iq_enq_valid, aq_enq_valid, dispatch_ack_by_way});
		check_value("cq_count", 0, cq_count);

		// six stores against the four-entry dq, iq stalled
		test_name = "accept";
		set_iq_ready(1'b0);
		for (int i = 0; i < 6; i++)
			to_send.push_back(make_op(SW, 5'(i), 6'(10 + i), 1'b0,
				6'((i % 2) ? 20 + i : 0), 1'b0, 2'b00));
		while (to_send.size() > 2)
			@(negedge CLK);
		repeat (6) @(negedge CLK);
		check_value("ops held", 4, exp_iq.size());
		check_value("ops waiting", 2, to_send.size());

		// PR 14 belongs to an op still outside the dq
		test_name = "wakeup";
		writeback(6'd10);
		writeback(6'd21);
		writeback(6'd14);
		set_iq_ready(1'b1);
		drain_and_check();
		commit(6);

		test_name = "routing";
		to_send.push_back(make_op(SB, 5'd6, 6'd1, 1'b1, 6'd2, 1'b1, 2'b00));
		to_send.push_back(make_op(SH, 5'd7, 6'd3, 1'b1, 6'd4, 1'b0, 2'b10));
		to_send.push_back(make_op(AMO_SWAP, 5'd8, 6'd5, 1'b1, 6'd0, 1'b0, 2'b01));
		to_send.push_back(make_op(FENCE, 5'd9, 6'd0, 1'b0, 6'd0, 1'b0, 2'b00));
		to_send.push_back(make_op(FENCE, 5'd10, 6'd0, 1'b0, 6'd0, 1'b0, 2'b10));
		to_send.push_back(make_op(AMO_ADD, 5'd11, 6'd30, 1'b0, 6'd31, 1'b1, 2'b00));
		drain_and_check();
		commit(6);

		// ROB 22 and 23 fall in the killed range
		test_name = "kill";
		set_iq_ready(1'b0);
		for (int i = 0; i < 4; i++)
			to_send.push_back(make_op(SW, 5'(20 + i), 6'(40 + i), 1'b1, 6'd0, 1'b0, 2'(i)));
		while (to_send.size() != 0)
			@(negedge CLK);
		kill(5'd16, 5'd6);
		set_iq_ready(1'b1);
		drain_and_check();
		commit(4);

		test_name = "cq full";
		for (int i = 0; i < 8; i++)
			to_send.push_back(make_op(FENCE, 5'(24 + i), 6'd0, 1'b0, 6'd0, 1'b0, 2'b00));
		to_send.push_back(make_op(SW, 5'd0, 6'd3, 1'b1, 6'd4, 1'b1, 2'b00));
		while (cq_count != 8)
			@(negedge CLK);
		repeat (6) @(negedge CLK);
		check_value("store held behind full cq", 1, exp_iq.size());
		check_value("cq_count at full", 8, cq_count);
		commit(1);
		drain_and_check();
		// last two commits find the cq empty
		commit(10);
		drain_and_check();

		test_name = "end";
		print_counts();
		if (errors == 0 && uut.checks.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/stamofu_pkg.sv
hw/stamofu_dispatch.sv
hw/stamofu_dq.sv
hw/stamofu_cq.sv
hw/stamofu_top.sv
tb/stamofu_asserts.sv
tb/stamofu_tb.sv
